/* sim.f */
src/axi_xbar_pkg.sv
src/axi_ar_if.sv
src/axi_r_if.sv
src/slave_read_arbiter.sv
src/read_data_return.sv
src/axi_read_interconnect.sv
bench/axi_slave_model.sv
bench/read_checker.sv
bench/axi_read_interconnect_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the read interconnect testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f sim.f \
    --top-module axi_read_interconnect_tb -o sim_tb

./obj_dir/sim_tb > sim.log 2>&1
cat sim.log

if grep -q "SIMULATION PASSED" sim.log; then
    echo "run_sim: pass"
else
    echo "run_sim: fail"
    exit 1
fi

/* bench/axi_read_interconnect_tb.sv */
`timescale 1ns/1ps

module axi_read_interconnect_tb;

    localparam int          CLK_PERIOD = 4;
    localparam int          N_ENTRIES  = 7;
    localparam int          MAX_BEATS  = 8;
    localparam int          WATCHDOG_CYCLES = N_ENTRIES * MAX_BEATS * 8 + 8;
    localparam logic [31:0] TAG1 = 32'h5A5A_0000;
    localparam logic [31:0] TAG2 = 32'h0000_C3C3;

    // Masters mask (bit 0 is master 1), both addresses, len, random rready
    typedef struct packed {
        logic [1:0]  mask;
        logic [31:0] addr1;
        logic [31:0] addr2;
        logic [7:0]  len;
        logic        stall;
    } entry_t;

    localparam entry_t STIM [N_ENTRIES] = '{
        '{2'b01, 32'h0000_1000, 32'h0000_0000, 8'd3, 1'b0},
        '{2'b10, 32'h0000_0000, 32'h8000_2000, 8'd4, 1'b0},
        '{2'b11, 32'h0000_0100, 32'h0000_0200, 8'd2, 1'b0},
        '{2'b11, 32'h9000_0000, 32'hA000_0010, 8'd5, 1'b0},
        '{2'b11, 32'h0000_3000, 32'hC000_0000, 8'd3, 1'b0},
        '{2'b11, 32'hF000_0040, 32'h0000_0040, 8'd7, 1'b1},
        '{2'b01, 32'h7FFF_FF00, 32'h0000_0000, 8'd7, 1'b1}
    };

    logic        clk = 1'b0;
    logic        i_reset = 1'b1;
    integer      seed = 59252;
    int          errors;
    int          bursts;
    int          expected_bursts = 0;
    int          extra_errors = 0;

    logic [31:0] m_araddr [2];
    logic [7:0]  m_arid [2];
    logic [7:0]  m_arlen [2];
    logic [2:0]  m_arsize [2];
    logic [1:0]  m_arburst [2];
    logic        m_arvalid [2];
    logic        m_arready [2];
    logic [7:0]  m_rid [2];
    logic [31:0] m_rdata [2];
    logic [1:0]  m_rresp [2];
    logic        m_rlast [2];
    logic        m_rvalid [2];
    logic        m_rready [2];
    logic [31:0] s_araddr [2];
    logic [7:0]  s_arid [2];
    logic [7:0]  s_arlen [2];
    logic [2:0]  s_arsize [2];
    logic [1:0]  s_arburst [2];
    logic        s_arvalid [2];
    logic        s_arready [2];
    logic [7:0]  s_rid [2];
    logic [31:0] s_rdata [2];
    logic [1:0]  s_rresp [2];
    logic        s_rlast [2];
    logic        s_rvalid [2];
    logic        s_rready [2];

    always #(CLK_PERIOD / 2) clk = ~clk;

    axi_read_interconnect DUT (
        .i_clk (clk), .i_reset (i_reset),
        .i_m1_araddr (m_araddr[0]), .i_m1_arid (m_arid[0]), .i_m1_arlen (m_arlen[0]),
        .i_m1_arsize (m_arsize[0]), .i_m1_arburst (m_arburst[0]),
        .i_m1_arvalid (m_arvalid[0]), .o_m1_arready (m_arready[0]),
        .o_m1_rid (m_rid[0]), .o_m1_rdata (m_rdata[0]), .o_m1_rresp (m_rresp[0]),
        .o_m1_rlast (m_rlast[0]), .o_m1_rvalid (m_rvalid[0]), .i_m1_rready (m_rready[0]),
        .i_m2_araddr (m_araddr[1]), .i_m2_arid (m_arid[1]), .i_m2_arlen (m_arlen[1]),
        .i_m2_arsize (m_arsize[1]), .i_m2_arburst (m_arburst[1]),
        .i_m2_arvalid (m_arvalid[1]), .o_m2_arready (m_arready[1]),
        .o_m2_rid (m_rid[1]), .o_m2_rdata (m_rdata[1]), .o_m2_rresp (m_rresp[1]),
        .o_m2_rlast (m_rlast[1]), .o_m2_rvalid (m_rvalid[1]), .i_m2_rready (m_rready[1]),
        .o_s1_araddr (s_araddr[0]), .o_s1_arid (s_arid[0]), .o_s1_arlen (s_arlen[0]),
        .o_s1_arsize (s_arsize[0]), .o_s1_arburst (s_arburst[0]),
        .o_s1_arvalid (s_arvalid[0]), .i_s1_arready (s_arready[0]),
        .i_s1_rid (s_rid[0]), .i_s1_rdata (s_rdata[0]), .i_s1_rresp (s_rresp[0]),
        .i_s1_rlast (s_rlast[0]), .i_s1_rvalid (s_rvalid[0]), .o_s1_rready (s_rready[0]),
        .o_s2_araddr (s_araddr[1]), .o_s2_arid (s_arid[1]), .o_s2_arlen (s_arlen[1]),
        .o_s2_arsize (s_arsize[1]), .o_s2_arburst (s_arburst[1]),
        .o_s2_arvalid (s_arvalid[1]), .i_s2_arready (s_arready[1]),
        .i_s2_rid (s_rid[1]), .i_s2_rdata (s_rdata[1]), .i_s2_rresp (s_rresp[1]),
        .i_s2_rlast (s_rlast[1]), .i_s2_rvalid (s_rvalid[1]), .o_s2_rready (s_rready[1])
    );

    axi_slave_model #(.TAG (TAG1)) u_slave1 (
        .i_clk (clk), .i_reset (i_reset),
        .i_araddr (s_araddr[0]), .i_arid (s_arid[0]), .i_arlen (s_arlen[0]),
        .i_arvalid (s_arvalid[0]), .o_arready (s_arready[0]),
        .o_rid (s_rid[0]), .o_rdata (s_rdata[0]), .o_rresp (s_rresp[0]),
        .o_rlast (s_rlast[0]), .o_rvalid (s_rvalid[0]), .i_rready (s_rready[0])
    );

    axi_slave_model #(.TAG (TAG2)) u_slave2 (
        .i_clk (clk), .i_reset (i_reset),
        .i_araddr (s_araddr[1]), .i_arid (s_arid[1]), .i_arlen (s_arlen[1]),
        .i_arvalid (s_arvalid[1]), .o_arready (s_arready[1]),
        .o_rid (s_rid[1]), .o_rdata (s_rdata[1]), .o_rresp (s_rresp[1]),
        .o_rlast (s_rlast[1]), .o_rvalid (s_rvalid[1]), .i_rready (s_rready[1])
    );

    read_checker #(.TAG1 (TAG1), .TAG2 (TAG2)) u_checker (
        .i_clk (clk), .i_reset (i_reset),
        .i_m_araddr (m_araddr), .i_m_arid (m_arid), .i_m_arlen (m_arlen),
        .i_m_arsize (m_arsize), .i_m_arburst (m_arburst),
        .i_m_arvalid (m_arvalid), .i_m_arready (m_arready),
        .i_m_rid (m_rid), .i_m_rdata (m_rdata), .i_m_rresp (m_rresp),
        .i_m_rlast (m_rlast), .i_m_rvalid (m_rvalid), .i_m_rready (m_rready),
        .i_s_araddr (s_araddr), .i_s_arid (s_arid), .i_s_arlen (s_arlen),
        .i_s_arsize (s_arsize), .i_s_arburst (s_arburst),
        .i_s_arvalid (s_arvalid), .i_s_arready (s_arready), .i_s_rready (s_rready),
        .o_errors (errors), .o_bursts (bursts)
    );

    function automatic logic pick_rready(input logic stall);
        return stall ? (($random(seed) & 3) != 0) : 1'b1;
    endfunction

    // One burst on master m with inputs changed 1 ns after the edge
    task automatic run_read(input int m, input logic [31:0] addr, input logic [7:0] id,
                            input logic [7:0] len, input logic stall);
        logic done;
        @(posedge clk);
        #1;
        m_araddr[m]  = addr;
        m_arid[m]    = id;
        m_arlen[m]   = len;
        m_arvalid[m] = 1'b1;
        m_rready[m]  = pick_rready(stall);
        @(negedge clk);
        while (!m_arready[m]) @(negedge clk);
        @(posedge clk);
        #1;
        m_arvalid[m] = 1'b0;
        done = 1'b0;
        while (!done) begin
            @(negedge clk);
            done = m_rvalid[m] && m_rready[m] && m_rlast[m];
            @(posedge clk);
            #1;
            m_rready[m] = pick_rready(stall);
        end
    endtask

    initial begin
        for (int m = 0; m < 2; m++) begin
            m_araddr[m]  = '0;
            m_arid[m]    = '0;
            m_arlen[m]   = '0;
            m_arvalid[m] = 1'b0;
            m_rready[m]  = 1'b0;
        end
        // Distinct size and burst per master so a crossed route shows at the slave
        m_arsize[0]  = 3'd2;
        m_arburst[0] = 2'd1;
        m_arsize[1]  = 3'd1;
        m_arburst[1] = 2'd0;
        repeat (4) @(posedge clk);
        #1;
        i_reset = 1'b0;
        repeat (3) @(posedge clk);
        for (int i = 0; i < N_ENTRIES; i++) begin
            expected_bursts += int'(STIM[i].mask[0]) + int'(STIM[i].mask[1]);
            fork
                if (STIM[i].mask[0])
                    run_read(0, STIM[i].addr1, {4'h1, 4'(i)}, STIM[i].len, STIM[i].stall);
                if (STIM[i].mask[1])
                    run_read(1, STIM[i].addr2, {4'h2, 4'(i)}, STIM[i].len, STIM[i].stall);
            join
        end
        repeat (4) @(posedge clk);
        if (bursts != expected_bursts) begin
            $display("Only %0d of %0d bursts completed", bursts, expected_bursts);
            extra_errors++;
        end
        $display("Checks finished: %0d errors, %0d bursts", errors + extra_errors, bursts);
        if (errors + extra_errors == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

    // Watchdog
    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("Timeout: the bursts did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("SIMULATION FAILED");
        $finish;
    end

endmodule

/* bench/read_checker.sv */
`timescale 1ns/1ps

// Watches master and slave ports and predicts every beat from the address map
module read_checker #(
    parameter logic [31:0] TAG1 = '0,
    parameter logic [31:0] TAG2 = '0
) (
    input  logic        i_clk,
    input  logic        i_reset,
    input  logic [31:0] i_m_araddr [2],
    input  logic [7:0]  i_m_arid [2],
    input  logic [7:0]  i_m_arlen [2],
    input  logic [2:0]  i_m_arsize [2],
    input  logic [1:0]  i_m_arburst [2],
    input  logic        i_m_arvalid [2],
    input  logic        i_m_arready [2],
    input  logic [7:0]  i_m_rid [2],
    input  logic [31:0] i_m_rdata [2],
    input  logic [1:0]  i_m_rresp [2],
    input  logic        i_m_rlast [2],
    input  logic        i_m_rvalid [2],
    input  logic        i_m_rready [2],
    input  logic [31:0] i_s_araddr [2],
    input  logic [7:0]  i_s_arid [2],
    input  logic [7:0]  i_s_arlen [2],
    input  logic [2:0]  i_s_arsize [2],
    input  logic [1:0]  i_s_arburst [2],
    input  logic        i_s_arvalid [2],
    input  logic        i_s_arready [2],
    input  logic        i_s_rready [2],
    output int          o_errors,
    output int          o_bursts
);

    int          cycle = 0;
    int          error_count = 0;
    int          burst_count = 0;
    bit          seen_req = 0;
    bit          waiting [2] = '{0, 0};
    bit          open [2] = '{0, 0};
    bit          busy [2] = '{0, 0};
    int          since [2];
    int          exp_slave [2];
    int          beat [2];
    logic [31:0] exp_local [2];
    logic [7:0]  exp_id [2];
    logic [7:0]  exp_len [2];

    assign o_errors = error_count;
    assign o_bursts = burst_count;

    task automatic report(input string msg);
        error_count++;
        $display("** Error [%0t ns] %s", $time, msg);
    endtask

    function automatic int slave_of(input logic [31:0] addr);
        return (addr >= axi_xbar_pkg::S1_WINDOW) ? 1 : 0;
    endfunction

    // Sampled mid-cycle once all inputs have settled
    always @(negedge i_clk) begin
        int          s;
        int          o;
        logic [31:0] exp_data;
        if (!i_reset) begin
            cycle++;
            if (!seen_req && (i_m_rvalid[0] || i_m_rvalid[1] || i_m_arready[0]
                    || i_m_arready[1] || i_s_arvalid[0] || i_s_arvalid[1]
                    || i_s_rready[0] || i_s_rready[1]))
                report("channel active before any request");
            for (int m = 0; m < 2; m++) begin
                if (i_m_arvalid[m]) seen_req = 1;
                if (i_m_arvalid[m] && !waiting[m]) begin
                    waiting[m] = 1;
                    since[m] = cycle;
                end
            end
            for (int m = 0; m < 2; m++) begin
                if (i_m_arvalid[m] && i_m_arready[m]) begin
                    s = slave_of(i_m_araddr[m]);
                    o = 1 - m;
                    exp_local[m] = i_m_araddr[m] - (s == 1 ? axi_xbar_pkg::S1_WINDOW : 32'h0);
                    if (!i_s_arvalid[s] || !i_s_arready[s]
                            || i_s_araddr[s] !== exp_local[m]
                            || i_s_arid[s] !== i_m_arid[m]
                            || i_s_arlen[s] !== i_m_arlen[m]
                            || i_s_arsize[s] !== i_m_arsize[m]
                            || i_s_arburst[s] !== i_m_arburst[m])
                        report($sformatf("master %0d request not seen at slave %0d as %h",
                            m + 1, s + 1, exp_local[m]));
                    if (busy[s])
                        report($sformatf("slave %0d granted while a burst is open", s + 1));
                    // An older or tied master 1 request to the same slave must go first
                    if (waiting[o] && slave_of(i_m_araddr[o]) == s
                            && (since[o] < since[m] || (since[o] == since[m] && o == 0)))
                        report($sformatf("master %0d overtook master %0d", m + 1, o + 1));
                    busy[s] = 1;
                    open[m] = 1;
                    waiting[m] = 0;
                    exp_slave[m] = s;
                    exp_id[m] = i_m_arid[m];
                    exp_len[m] = i_m_arlen[m];
                    beat[m] = 0;
                end
            end
            for (int m = 0; m < 2; m++) begin
                // Slave rready follows the owning master for the whole burst
                if (open[m] && i_s_rready[exp_slave[m]] !== i_m_rready[m])
                    report($sformatf("slave %0d rready does not follow master %0d",
                        exp_slave[m] + 1, m + 1));
                if (i_m_rvalid[m] && i_m_rready[m]) begin
                    exp_data = (exp_local[m] + (32'(beat[m]) << 2))
                        ^ (exp_slave[m] == 1 ? TAG2 : TAG1);
                    if (!open[m]) begin
                        report($sformatf("master %0d got a beat with no open burst", m + 1));
                    end else begin
                        if (i_m_rdata[m] !== exp_data || i_m_rid[m] !== exp_id[m])
                            report($sformatf("master %0d beat %0d: data %h id %h, want %h %h",
                                m + 1, beat[m], i_m_rdata[m], i_m_rid[m], exp_data, exp_id[m]));
                        if (i_m_rresp[m] !== 2'b00)
                            report($sformatf("master %0d beat %0d: rresp %b, want OKAY",
                                m + 1, beat[m], i_m_rresp[m]));
                        if (i_m_rlast[m] !== (beat[m] == int'(exp_len[m])))
                            report($sformatf("master %0d rlast wrong on beat %0d",
                                m + 1, beat[m]));
                        if (i_m_rlast[m] || beat[m] == int'(exp_len[m])) begin
                            open[m] = 0;
                            busy[exp_slave[m]] = 0;
                            burst_count++;
                        end
                        beat[m]++;
                    end
                end
            end
        end
    end

endmodule

/* bench/axi_slave_model.sv */
`timescale 1ns/1ps

// Behavioral read slave, one burst at a time
module axi_slave_model #(
    parameter logic [axi_xbar_pkg::DATA_W-1:0] TAG = '0
) (
    input  logic                             i_clk,
    input  logic                             i_reset,
    input  logic [axi_xbar_pkg::ADDR_W-1:0]  i_araddr,
    input  logic [axi_xbar_pkg::ID_W-1:0]    i_arid,
    input  logic [axi_xbar_pkg::LEN_W-1:0]   i_arlen,
    input  logic                             i_arvalid,
    output logic                             o_arready,
    output logic [axi_xbar_pkg::ID_W-1:0]    o_rid,
    output logic [axi_xbar_pkg::DATA_W-1:0]  o_rdata,
    output logic [axi_xbar_pkg::RESP_W-1:0]  o_rresp,
    output logic                             o_rlast,
    output logic                             o_rvalid,
    input  logic                             i_rready
);

    logic                            busy;
    logic [axi_xbar_pkg::ADDR_W-1:0] addr;
    logic [axi_xbar_pkg::LEN_W-1:0]  len;
    logic [axi_xbar_pkg::LEN_W-1:0]  beat;

    assign o_arready = !busy;
    assign o_rvalid  = busy;
    assign o_rresp   = '0;
    assign o_rlast   = busy && (beat == len);
    // Beat k carries local address plus 4k, tagged per slave
    assign o_rdata   = (addr + (32'(beat) << 2)) ^ TAG;

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            busy  <= 1'b0;
            addr  <= '0;
            len   <= '0;
            beat  <= '0;
            o_rid <= '0;
        end else if (!busy && i_arvalid) begin
            busy  <= 1'b1;
            addr  <= i_araddr;
            len   <= i_arlen;
            beat  <= '0;
            o_rid <= i_arid;
        end else if (busy && i_rready) begin
            if (beat == len) begin
                busy <= 1'b0;
            end else begin
                beat <= beat + 8'd1;
            end
        end
    end

endmodule

/* src/axi_read_interconnect.sv */
`timescale 1ns/1ps

module axi_read_interconnect (
    input  logic                               i_clk,
    input  logic                               i_reset,

    // Master 1 read address
    input  logic [axi_xbar_pkg::ADDR_W-1:0]    i_m1_araddr,
    input  logic [axi_xbar_pkg::ID_W-1:0]      i_m1_arid,
    input  logic [axi_xbar_pkg::LEN_W-1:0]     i_m1_arlen,
    input  logic [axi_xbar_pkg::SIZE_W-1:0]    i_m1_arsize,
    input  logic [axi_xbar_pkg::BURST_W-1:0]   i_m1_arburst,
    input  logic                               i_m1_arvalid,
    output logic                               o_m1_arready,
    // Master 1 read data
    output logic [axi_xbar_pkg::ID_W-1:0]      o_m1_rid,
    output logic [axi_xbar_pkg::DATA_W-1:0]    o_m1_rdata,
    output logic [axi_xbar_pkg::RESP_W-1:0]    o_m1_rresp,
    output logic                               o_m1_rlast,
    output logic                               o_m1_rvalid,
    input  logic                               i_m1_rready,

    // Master 2 read address
    input  logic [axi_xbar_pkg::ADDR_W-1:0]    i_m2_araddr,
    input  logic [axi_xbar_pkg::ID_W-1:0]      i_m2_arid,
    input  logic [axi_xbar_pkg::LEN_W-1:0]     i_m2_arlen,
    input  logic [axi_xbar_pkg::SIZE_W-1:0]    i_m2_arsize,
    input  logic [axi_xbar_pkg::BURST_W-1:0]   i_m2_arburst,
    input  logic                               i_m2_arvalid,
    output logic                               o_m2_arready,
    // Master 2 read data
    output logic [axi_xbar_pkg::ID_W-1:0]      o_m2_rid,
    output logic [axi_xbar_pkg::DATA_W-1:0]    o_m2_rdata,
    output logic [axi_xbar_pkg::RESP_W-1:0]    o_m2_rresp,
    output logic                               o_m2_rlast,
    output logic                               o_m2_rvalid,
    input  logic                               i_m2_rready,

    // Slave 1 read address
    output logic [axi_xbar_pkg::ADDR_W-1:0]    o_s1_araddr,
    output logic [axi_xbar_pkg::ID_W-1:0]      o_s1_arid,
    output logic [axi_xbar_pkg::LEN_W-1:0]     o_s1_arlen,
    output logic [axi_xbar_pkg::SIZE_W-1:0]    o_s1_arsize,
    output logic [axi_xbar_pkg::BURST_W-1:0]   o_s1_arburst,
    output logic                               o_s1_arvalid,
    input  logic                               i_s1_arready,
    // Slave 1 read data
    input  logic [axi_xbar_pkg::ID_W-1:0]      i_s1_rid,
    input  logic [axi_xbar_pkg::DATA_W-1:0]    i_s1_rdata,
    input  logic [axi_xbar_pkg::RESP_W-1:0]    i_s1_rresp,
    input  logic                               i_s1_rlast,
    input  logic                               i_s1_rvalid,
    output logic                               o_s1_rready,

    // Slave 2 read address
    output logic [axi_xbar_pkg::ADDR_W-1:0]    o_s2_araddr,
    output logic [axi_xbar_pkg::ID_W-1:0]      o_s2_arid,
    output logic [axi_xbar_pkg::LEN_W-1:0]     o_s2_arlen,
    output logic [axi_xbar_pkg::SIZE_W-1:0]    o_s2_arsize,
    output logic [axi_xbar_pkg::BURST_W-1:0]   o_s2_arburst,
    output logic                               o_s2_arvalid,
    input  logic                               i_s2_arready,
    // Slave 2 read data
    input  logic [axi_xbar_pkg::ID_W-1:0]      i_s2_rid,
    input  logic [axi_xbar_pkg::DATA_W-1:0]    i_s2_rdata,
    input  logic [axi_xbar_pkg::RESP_W-1:0]    i_s2_rresp,
    input  logic                               i_s2_rlast,
    input  logic                               i_s2_rvalid,
    output logic                               o_s2_rready
);

    axi_ar_if m1_ar ();
    axi_ar_if m2_ar ();
    axi_ar_if s1_ar ();
    axi_ar_if s2_ar ();
    axi_r_if  m1_r ();
    axi_r_if  m2_r ();
    axi_r_if  s1_r ();
    axi_r_if  s2_r ();

    axi_xbar_pkg::grant_t s1_grant;
    axi_xbar_pkg::grant_t s2_grant;

    // Master side onto the bundles
    assign m1_ar.addr   = i_m1_araddr;
    assign m1_ar.id     = i_m1_arid;
    assign m1_ar.len    = i_m1_arlen;
    assign m1_ar.size   = i_m1_arsize;
    assign m1_ar.burst  = i_m1_arburst;
    assign m1_ar.valid  = i_m1_arvalid;
    assign o_m1_arready = m1_ar.ready;
    assign o_m1_rid     = m1_r.id;
    assign o_m1_rdata   = m1_r.data;
    assign o_m1_rresp   = m1_r.resp;
    assign o_m1_rlast   = m1_r.last;
    assign o_m1_rvalid  = m1_r.valid;
    assign m1_r.ready   = i_m1_rready;

    assign m2_ar.addr   = i_m2_araddr;
    assign m2_ar.id     = i_m2_arid;
    assign m2_ar.len    = i_m2_arlen;
    assign m2_ar.size   = i_m2_arsize;
    assign m2_ar.burst  = i_m2_arburst;
    assign m2_ar.valid  = i_m2_arvalid;
    assign o_m2_arready = m2_ar.ready;
    assign o_m2_rid     = m2_r.id;
    assign o_m2_rdata   = m2_r.data;
    assign o_m2_rresp   = m2_r.resp;
    assign o_m2_rlast   = m2_r.last;
    assign o_m2_rvalid  = m2_r.valid;
    assign m2_r.ready   = i_m2_rready;

    // Slave side onto the bundles
    assign o_s1_araddr  = s1_ar.addr;
    assign o_s1_arid    = s1_ar.id;
    assign o_s1_arlen   = s1_ar.len;
    assign o_s1_arsize  = s1_ar.size;
    assign o_s1_arburst = s1_ar.burst;
    assign o_s1_arvalid = s1_ar.valid;
    assign s1_ar.ready  = i_s1_arready;
    assign s1_r.id      = i_s1_rid;
    assign s1_r.data    = i_s1_rdata;
    assign s1_r.resp    = i_s1_rresp;
    assign s1_r.last    = i_s1_rlast;
    assign s1_r.valid   = i_s1_rvalid;
    assign o_s1_rready  = s1_r.ready;

    assign o_s2_araddr  = s2_ar.addr;
    assign o_s2_arid    = s2_ar.id;
    assign o_s2_arlen   = s2_ar.len;
    assign o_s2_arsize  = s2_ar.size;
    assign o_s2_arburst = s2_ar.burst;
    assign o_s2_arvalid = s2_ar.valid;
    assign s2_ar.ready  = i_s2_arready;
    assign s2_r.id      = i_s2_rid;
    assign s2_r.data    = i_s2_rdata;
    assign s2_r.resp    = i_s2_rresp;
    assign s2_r.last    = i_s2_rlast;
    assign s2_r.valid   = i_s2_rvalid;
    assign o_s2_rready  = s2_r.ready;

    // Low window
    slave_read_arbiter #(
        .BASE ('0),
        .SIZE ({1'b0, axi_xbar_pkg::S1_WINDOW})
    ) u_arb_s1 (
        .i_clk       (i_clk),
        .i_reset     (i_reset),
        .m1_ar       (m1_ar),
        .m2_ar       (m2_ar),
        .s_ar        (s1_ar),
        .i_m1_rready (m1_r.ready),
        .i_m2_rready (m2_r.ready),
        .i_rvalid    (s1_r.valid),
        .i_rlast     (s1_r.last),
        .o_rready    (s1_r.ready),
        .o_grant     (s1_grant)
    );

    // High window, addresses re-based to zero
    slave_read_arbiter #(
        .BASE (axi_xbar_pkg::S1_WINDOW),
        .SIZE (axi_xbar_pkg::S2_WINDOW)
    ) u_arb_s2 (
        .i_clk       (i_clk),
        .i_reset     (i_reset),
        .m1_ar       (m1_ar),
        .m2_ar       (m2_ar),
        .s_ar        (s2_ar),
        .i_m1_rready (m1_r.ready),
        .i_m2_rready (m2_r.ready),
        .i_rvalid    (s2_r.valid),
        .i_rlast     (s2_r.last),
        .o_rready    (s2_r.ready),
        .o_grant     (s2_grant)
    );

    read_data_return #(
        .MASTER_BIT (0)
    ) u_ret_m1 (
        .s1_r         (s1_r),
        .s2_r         (s2_r),
        .i_s1_arready (s1_ar.ready),
        .i_s2_arready (s2_ar.ready),
        .i_s1_grant   (s1_grant),
        .i_s2_grant   (s2_grant),
        .m_r          (m1_r),
        .o_arready    (m1_ar.ready)
    );

    read_data_return #(
        .MASTER_BIT (1)
    ) u_ret_m2 (
        .s1_r         (s1_r),
        .s2_r         (s2_r),
        .i_s1_arready (s1_ar.ready),
        .i_s2_arready (s2_ar.ready),
        .i_s1_grant   (s1_grant),
        .i_s2_grant   (s2_grant),
        .m_r          (m2_r),
        .o_arready    (m2_ar.ready)
    );

endmodule

/* src/read_data_return.sv */
`timescale 1ns/1ps

module read_data_return #(
    parameter int MASTER_BIT = 0
) (
    axi_r_if.master              s1_r,
    axi_r_if.master              s2_r,
    input  logic                 i_s1_arready,
    input  logic                 i_s2_arready,
    input  axi_xbar_pkg::grant_t i_s1_grant,
    input  axi_xbar_pkg::grant_t i_s2_grant,
    axi_r_if.slave               m_r,
    output logic                 o_arready
);

    logic sel_s1;
    logic sel_s2;
    logic rvalid_sel;

    // Does each slave currently belong to this master
    assign sel_s1 = i_s1_grant[MASTER_BIT];
    assign sel_s2 = i_s2_grant[MASTER_BIT];

    // Slave 1 takes precedence if both point here
    always_comb begin
        m_r.id     = '0;
        m_r.data   = '0;
        m_r.resp   = '0;
        m_r.last   = 1'b0;
        rvalid_sel = 1'b0;
        o_arready  = 1'b0;
        if (sel_s1) begin
            m_r.id     = s1_r.id;
            m_r.data   = s1_r.data;
            m_r.resp   = s1_r.resp;
            m_r.last   = s1_r.last;
            rvalid_sel = s1_r.valid;
            o_arready  = i_s1_arready;
        end else if (sel_s2) begin
            m_r.id     = s2_r.id;
            m_r.data   = s2_r.data;
            m_r.resp   = s2_r.resp;
            m_r.last   = s2_r.last;
            rvalid_sel = s2_r.valid;
            o_arready  = i_s2_arready;
        end
        // No beat reaches a master without a grant
        assert (!rvalid_sel || sel_s1 || sel_s2)
            else $error("read_data_return: rvalid without grant");
    end

    assign m_r.valid = rvalid_sel;

endmodule

/* src/slave_read_arbiter.sv */
`timescale 1ns/1ps

module slave_read_arbiter #(
    parameter logic [axi_xbar_pkg::ADDR_W-1:0] BASE = '0,
    parameter logic [axi_xbar_pkg::ADDR_W:0]   SIZE = {1'b0, axi_xbar_pkg::S1_WINDOW}
) (
    input  logic                 i_clk,
    input  logic                 i_reset,
    axi_ar_if.slave              m1_ar,
    axi_ar_if.slave              m2_ar,
    axi_ar_if.master             s_ar,
    input  logic                 i_m1_rready,
    input  logic                 i_m2_rready,
    input  logic                 i_rvalid,
    input  logic                 i_rlast,
    output logic                 o_rready,
    output axi_xbar_pkg::grant_t o_grant
);

    // Offsets carry a borrow bit, so an address below BASE lands out of range
    logic [axi_xbar_pkg::ADDR_W:0] m1_offset;
    logic [axi_xbar_pkg::ADDR_W:0] m2_offset;
    logic                          m1_req;
    logic                          m2_req;
    logic                          last_beat;
    axi_xbar_pkg::grant_t          grant;

    assign m1_offset = {1'b0, m1_ar.addr} - {1'b0, BASE};
    assign m2_offset = {1'b0, m2_ar.addr} - {1'b0, BASE};

    // Window decode
    assign m1_req = m1_ar.valid && (m1_offset < SIZE);
    assign m2_req = m2_ar.valid && (m2_offset < SIZE);

    // Final beat of the open burst leaves the slave
    assign last_beat = i_rvalid && o_rready && i_rlast;

    // Grant register, master 1 wins a tie
    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            grant <= '0;
        end else if (grant == '0) begin
            if (m1_req) begin
                grant <= 2'b01;
            end else if (m2_req) begin
                grant <= 2'b10;
            end
        end else if (last_beat) begin
            grant <= '0;
        end
    end

    assign o_grant = grant;

    // Forward the granted master, idle slave sees all zeros
    always_comb begin
        s_ar.addr  = '0;
        s_ar.id    = '0;
        s_ar.len   = '0;
        s_ar.size  = '0;
        s_ar.burst = '0;
        s_ar.valid = 1'b0;
        o_rready   = 1'b0;
        case (grant)
            2'b01: begin
                s_ar.addr  = m1_offset[axi_xbar_pkg::ADDR_W-1:0];
                s_ar.id    = m1_ar.id;
                s_ar.len   = m1_ar.len;
                s_ar.size  = m1_ar.size;
                s_ar.burst = m1_ar.burst;
                s_ar.valid = m1_ar.valid;
                o_rready   = i_m1_rready;
            end
            2'b10: begin
                s_ar.addr  = m2_offset[axi_xbar_pkg::ADDR_W-1:0];
                s_ar.id    = m2_ar.id;
                s_ar.len   = m2_ar.len;
                s_ar.size  = m2_ar.size;
                s_ar.burst = m2_ar.burst;
                s_ar.valid = m2_ar.valid;
                o_rready   = i_m2_rready;
            end
            default: begin
                o_rready = 1'b0;
            end
        endcase
    end

    // Never two owners at once
    a_grant_onehot : assert property (
        @(posedge i_clk) disable iff (i_reset)
        $onehot0(grant)
    ) else $error("slave_read_arbiter: grant %b is not one-hot", grant);

    // Owner only released by the accepted last beat
    a_grant_held : assert property (
        @(posedge i_clk) disable iff (i_reset)
        (grant != '0 && !last_beat) |=> $stable(grant)
    ) else $error("slave_read_arbiter: grant moved during an open burst");

endmodule

/* src/axi_r_if.sv */
`timescale 1ns/1ps

// One AXI read data channel
interface axi_r_if;

    logic [axi_xbar_pkg::ID_W-1:0]   id;
    logic [axi_xbar_pkg::DATA_W-1:0] data;
    logic [axi_xbar_pkg::RESP_W-1:0] resp;
    logic                            last;
    logic                            valid;
    logic                            ready;

    // Receiving side of the data beats
    modport master (
        input  id,
        input  data,
        input  resp,
        input  last,
        input  valid,
        output ready
    );

    // Returning side of the data beats
    modport slave (
        output id,
        output data,
        output resp,
        output last,
        output valid,
        input  ready
    );

endinterface

/* src/axi_ar_if.sv */
`timescale 1ns/1ps

// One AXI read address channel
interface axi_ar_if;

    logic [axi_xbar_pkg::ADDR_W-1:0]  addr;
    logic [axi_xbar_pkg::ID_W-1:0]    id;
    logic [axi_xbar_pkg::LEN_W-1:0]   len;
    logic [axi_xbar_pkg::SIZE_W-1:0]  size;
    logic [axi_xbar_pkg::BURST_W-1:0] burst;
    logic                             valid;
    logic                             ready;

    // Issuing side
    modport master (
        output addr,
        output id,
        output len,
        output size,
        output burst,
        output valid,
        input  ready
    );

    // Accepting side
    modport slave (
        input  addr,
        input  id,
        input  len,
        input  size,
        input  burst,
        input  valid,
        output ready
    );

endinterface

/* src/axi_xbar_pkg.sv */
package axi_xbar_pkg;

    // AXI read channel field widths
    localparam int ADDR_W  = 32;
    localparam int DATA_W  = 32;
    localparam int ID_W    = 8;
    localparam int LEN_W   = 8;
    localparam int SIZE_W  = 3;
    localparam int BURST_W = 2;
    localparam int RESP_W  = 2;

    // Masters sharing each slave
    localparam int N_MASTERS = 2;

    // Slave 1 owns the low window starting at zero
    localparam logic [ADDR_W-1:0] S1_WINDOW = 32'h8000_0000;

    // Whole address space, one bit wider than an address
    localparam logic [ADDR_W:0] ADDR_SPACE = {1'b1, {ADDR_W{1'b0}}};

    // Slave 2 takes everything above slave 1
    localparam logic [ADDR_W:0] S2_WINDOW = ADDR_SPACE - {1'b0, S1_WINDOW};

    // One-hot grant, bit 0 is master 1 and bit 1 is master 2
    typedef logic [N_MASTERS-1:0] grant_t;

endpackage
